// ==== rtl/cmul_defs.svh ====
`ifndef CMUL_DEFS_SVH
`define CMUL_DEFS_SVH

// width of one real or imaginary part
`define CMUL_WIDTH 32

// fraction bits, the rest of the word is integer part
`define CMUL_FRAC 16

// twiddle index width, table holds 2**TWID_ADDR_BITS entries
`define TWID_ADDR_BITS 4

// request queue in front of the twiddle stage
`define IN_FIFO_DEPTH 4

// result queue behind the multiplier
`define OUT_FIFO_DEPTH 4

`endif

// ==== rtl/fixed_pkg.sv ====
`include "cmul_defs.svh"

package fixed_pkg;

  // one signed fixed-point word
  typedef logic signed [`CMUL_WIDTH-1:0] fix_t;

  // complex value, real part in the upper half
  typedef struct packed {
    fix_t re;
    fix_t im;
  } cplx_t;

  // fixed-point product
  // full signed product, arithmetic shift drops the extra fraction bits
  // keeping the low word truncates toward minus infinity and wraps
  function automatic fix_t fix_mul(input fix_t x, input fix_t y);
    logic signed [2*`CMUL_WIDTH-1:0] full;
    logic signed [2*`CMUL_WIDTH-1:0] shifted;
    full = x * y;
    shifted = full >>> `CMUL_FRAC;
    return shifted[`CMUL_WIDTH-1:0];
  endfunction

endpackage

// ==== rtl/stream_pkg.sv ====
`include "cmul_defs.svh"

package stream_pkg;

  // selects one entry of the twiddle table
  typedef logic [`TWID_ADDR_BITS-1:0] twid_idx_t;

  // one rotation request from outside
  typedef struct packed {
    fixed_pkg::cplx_t sample;
    twid_idx_t        idx;
  } rot_req_t;

  // operand pair held by the twiddle stage for the multiplier
  // a is the sample, b the looked-up twiddle factor
  typedef struct packed {
    fixed_pkg::cplx_t a;
    fixed_pkg::cplx_t b;
  } mul_operands_t;

endpackage

// ==== rtl/stream_fifo.sv ====
`timescale 1ns/10ps

module stream_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = 4
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     in_val,
  output logic     in_rdy,
  input  payload_t in_data,
  output logic     out_val,
  input  logic     out_rdy,
  output payload_t out_data
);

  // pointer and occupancy widths, at least one bit each
  localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_bits = $clog2(depth + 1);

  localparam logic [ptr_bits-1:0] last_ptr   = ptr_bits'(depth - 1);
  localparam logic [cnt_bits-1:0] full_count = cnt_bits'(depth);

  payload_t mem [depth];

  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;
  logic [cnt_bits-1:0] count;
  logic                push;
  logic                pop;

  // ready while not full, valid while not empty
  assign in_rdy  = (count != full_count);
  assign out_val = (count != '0);
  assign push    = in_val && in_rdy;
  assign pop     = out_val && out_rdy;

  // head entry straight from storage
  assign out_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage write, the pointers track what is live
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

endmodule

// ==== rtl/twiddle_stage.sv ====
`timescale 1ns/10ps
`include "cmul_defs.svh"

module twiddle_stage (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      in_val,
  output logic                      in_rdy,
  input  stream_pkg::rot_req_t      in_req,
  output logic                      out_val,
  input  logic                      out_rdy,
  output stream_pkg::mul_operands_t out_ops
);
  import fixed_pkg::*;
  import stream_pkg::*;

  localparam int  table_size = 1 << `TWID_ADDR_BITS;
  localparam real pi         = 3.14159265358979323846;
  localparam real frac_scale = real'(1 << `CMUL_FRAC);

  // round to nearest, halves away from zero
  function automatic fix_t round_fix(input real v);
    if (v >= 0.0) begin
      return fix_t'($rtoi(v + 0.5));
    end
    return fix_t'(-$rtoi(0.5 - v));
  endfunction

  // entry k is cos(2*pi*k/N) - j*sin(2*pi*k/N)
  // taylor series on the angle folded into [-pi, pi]
  function automatic cplx_t twiddle_entry(input int k);
    real   x;
    real   term_c;
    real   term_s;
    real   c;
    real   s;
    cplx_t e;
    x = 2.0 * pi * real'(k) / real'(table_size);
    if (x > pi) begin
      x = x - 2.0 * pi;
    end
    term_c = 1.0;
    term_s = x;
    c = 1.0;
    s = x;
    for (int n = 1; n < 14; n++) begin
      term_c = -term_c * x * x / real'((2 * n - 1) * (2 * n));
      term_s = -term_s * x * x / real'((2 * n) * (2 * n + 1));
      c = c + term_c;
      s = s + term_s;
    end
    e.re = round_fix(c * frac_scale);
    e.im = round_fix(-s * frac_scale);
    return e;
  endfunction

  cplx_t         twid_rom [table_size];
  mul_operands_t ops_q;
  logic          slot_val;

  // table entries fixed at elaboration
  for (genvar k = 0; k < table_size; k++) begin : g_rom
    localparam cplx_t entry = twiddle_entry(k);
    assign twid_rom[k] = entry;
  end

  // slot takes a new request when empty or being drained this cycle
  assign in_rdy  = !slot_val || out_rdy;
  assign out_val = slot_val;
  assign out_ops = ops_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      slot_val <= 1'b0;
    end else if (in_rdy) begin
      slot_val <= in_val;
    end
  end

  // sample and its twiddle are registered together
  always_ff @(posedge clk) begin
    if (in_val && in_rdy) begin
      ops_q.a <= in_req.sample;
      ops_q.b <= twid_rom[in_req.idx];
    end
  end

endmodule

// ==== rtl/complex_multiplier.sv ====
`timescale 1ns/10ps

module complex_multiplier #(
  parameter int NUM_MULTS = 1
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      in_val,
  output logic                      in_rdy,
  input  stream_pkg::mul_operands_t in_ops,
  output logic                      out_val,
  input  logic                      out_rdy,
  output fixed_pkg::cplx_t          out_prod
);
  import fixed_pkg::*;
  import stream_pkg::*;

  // three-product form
  // re = ar*br - ac*bc
  // im = (ar+ac)(br+bc) - ar*br - ac*bc
  fix_t p1;
  fix_t p2;
  fix_t p3;

  if (NUM_MULTS == 3) begin : g_parallel
    fix_t sum_a;
    fix_t sum_b;

    // operand sums wrap in the word width
    assign sum_a = in_ops.a.re + in_ops.a.im;
    assign sum_b = in_ops.b.re + in_ops.b.im;

    // all three products in the same cycle
    assign p1 = fix_mul(in_ops.a.re, in_ops.b.re);
    assign p2 = fix_mul(in_ops.a.im, in_ops.b.im);
    assign p3 = fix_mul(sum_a, sum_b);

    // no storage, handshake passes straight through
    assign in_rdy  = out_rdy;
    assign out_val = in_val;
  end else begin : g_serial
    typedef enum logic [2:0] {
      st_idle,
      st_mul1,
      st_mul2,
      st_mul3,
      st_done
    } state_t;

    state_t        state;
    state_t        next_state;
    mul_operands_t ops_q;
    fix_t          p1_q;
    fix_t          p2_q;
    fix_t          p3_q;
    fix_t          sum_a;
    fix_t          sum_b;
    fix_t          mul_x;
    fix_t          mul_y;
    fix_t          mul_p;

    // sums taken from the captured operands
    assign sum_a = ops_q.a.re + ops_q.a.im;
    assign sum_b = ops_q.b.re + ops_q.b.im;

    // the one shared multiplier
    assign mul_p = fix_mul(mul_x, mul_y);

    always_ff @(posedge clk) begin
      if (reset) begin
        state <= st_idle;
      end else begin
        state <= next_state;
      end
    end

    // operand capture on acceptance, then one product per state
    always_ff @(posedge clk) begin
      if (state == st_idle && in_val) begin
        ops_q <= in_ops;
      end
      case (state)
        st_mul1: p1_q <= mul_p;
        st_mul2: p2_q <= mul_p;
        st_mul3: p3_q <= mul_p;
        default: ;
      endcase
    end

    always_comb begin
      next_state = state;
      in_rdy     = 1'b0;
      out_val    = 1'b0;
      mul_x      = '0;
      mul_y      = '0;
      case (state)
        st_idle: begin
          // only state that takes a new pair
          in_rdy = 1'b1;
          if (in_val) begin
            next_state = st_mul1;
          end
        end
        st_mul1: begin
          mul_x      = ops_q.a.re;
          mul_y      = ops_q.b.re;
          next_state = st_mul2;
        end
        st_mul2: begin
          mul_x      = ops_q.a.im;
          mul_y      = ops_q.b.im;
          next_state = st_mul3;
        end
        st_mul3: begin
          mul_x      = sum_a;
          mul_y      = sum_b;
          next_state = st_done;
        end
        st_done: begin
          // result held until the output queue takes it
          out_val = 1'b1;
          if (out_rdy) begin
            next_state = st_idle;
          end
        end
        default: next_state = st_idle;
      endcase
    end

    assign p1 = p1_q;
    assign p2 = p2_q;
    assign p3 = p3_q;
  end

  // shared combine step, all wrapping
  assign out_prod.re = p1 - p2;
  assign out_prod.im = p3 - p1 - p2;

endmodule

// ==== rtl/twiddle_rotator_top.sv ====
`timescale 1ns/10ps
`include "cmul_defs.svh"

module twiddle_rotator_top #(
  parameter int NUM_MULTS = 1
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_val,
  output logic                 in_rdy,
  input  stream_pkg::rot_req_t in_req,
  output logic                 out_val,
  input  logic                 out_rdy,
  output fixed_pkg::cplx_t     out_data
);
  import fixed_pkg::*;
  import stream_pkg::*;

  // input queue to twiddle stage
  logic          req_val;
  logic          req_rdy;
  rot_req_t      req;

  // twiddle stage to multiplier
  logic          ops_val;
  logic          ops_rdy;
  mul_operands_t ops;

  // multiplier to output queue
  logic          prod_val;
  logic          prod_rdy;
  cplx_t         prod;

  stream_fifo #(
    .payload_t (rot_req_t),
    .depth     (`IN_FIFO_DEPTH)
  ) in_fifo_i (
    .clk      (clk),
    .reset    (reset),
    .in_val   (in_val),
    .in_rdy   (in_rdy),
    .in_data  (in_req),
    .out_val  (req_val),
    .out_rdy  (req_rdy),
    .out_data (req)
  );

  twiddle_stage twiddle_i (
    .clk     (clk),
    .reset   (reset),
    .in_val  (req_val),
    .in_rdy  (req_rdy),
    .in_req  (req),
    .out_val (ops_val),
    .out_rdy (ops_rdy),
    .out_ops (ops)
  );

  complex_multiplier #(
    .NUM_MULTS (NUM_MULTS)
  ) cmul_i (
    .clk      (clk),
    .reset    (reset),
    .in_val   (ops_val),
    .in_rdy   (ops_rdy),
    .in_ops   (ops),
    .out_val  (prod_val),
    .out_rdy  (prod_rdy),
    .out_prod (prod)
  );

  stream_fifo #(
    .payload_t (cplx_t),
    .depth     (`OUT_FIFO_DEPTH)
  ) out_fifo_i (
    .clk      (clk),
    .reset    (reset),
    .in_val   (prod_val),
    .in_rdy   (prod_rdy),
    .in_data  (prod),
    .out_val  (out_val),
    .out_rdy  (out_rdy),
    .out_data (out_data)
  );

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int period_ns    = 40,
  parameter int reset_cycles = 10
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // reset held for a fixed number of rising edges
  initial begin
    reset <= 1'b1;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// ==== dv/rotator_checker.sv ====
`timescale 1ns/10ps
`include "cmul_defs.svh"

module rotator_checker (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_val,
  input  logic                 in_rdy,
  input  stream_pkg::rot_req_t in_req,
  input  logic                 out_val,
  input  logic                 out_rdy,
  input  fixed_pkg::cplx_t     out_data,
  input  logic                 end_check,
  output int                   errors,
  output int                   pending,
  output int                   checked
);
  import fixed_pkg::*;
  import stream_pkg::*;

  localparam int table_size = 1 << `TWID_ADDR_BITS;

  // one outstanding request, product precomputed at acceptance
  typedef struct packed {
    cplx_t     product;
    cplx_t     sample;
    twid_idx_t idx;
  } exp_entry_t;

  cplx_t      twid_model [table_size];
  exp_entry_t exp_q [$];
  exp_entry_t fresh;
  exp_entry_t head;
  int         err_count = 0;
  int         chk_count = 0;
  int         q_size    = 0;
  logic       end_done  = 1'b0;

  assign errors  = err_count;
  assign checked = chk_count;
  assign pending = q_size;

  // 64-bit product, arithmetic shift, low word kept
  function automatic fix_t trunc_mul(input fix_t x, input fix_t y);
    longint prod;
    prod = (longint'(x) * longint'(y)) >>> `CMUL_FRAC;
    return prod[`CMUL_WIDTH-1:0];
  endfunction

  // three products, every sum and difference wraps
  function automatic cplx_t rotate(input cplx_t a, input cplx_t b);
    fix_t  p1;
    fix_t  p2;
    fix_t  p3;
    cplx_t r;
    p1 = trunc_mul(a.re, b.re);
    p2 = trunc_mul(a.im, b.im);
    p3 = trunc_mul(a.re + a.im, b.re + b.im);
    r.re = p1 - p2;
    r.im = p3 - p1 - p2;
    return r;
  endfunction

  // cos and -sin scaled by the fraction bits, nearest integer
  initial begin
    real ang;
    real scale;
    scale = real'(1 << `CMUL_FRAC);
    for (int k = 0; k < table_size; k++) begin
      ang = 2.0 * 3.14159265358979 * real'(k) / real'(table_size);
      twid_model[k].re = fix_t'($rtoi($floor(scale * $cos(ang) + 0.5)));
      twid_model[k].im = fix_t'($rtoi($floor(-scale * $sin(ang) + 0.5)));
    end
  end

  always @(posedge clk) begin
    if (!reset) begin
      if (in_val && in_rdy) begin
        fresh.sample  = in_req.sample;
        fresh.idx     = in_req.idx;
        fresh.product = rotate(in_req.sample, twid_model[in_req.idx]);
        exp_q.push_back(fresh);
      end
      if (out_val && out_rdy) begin
        if (exp_q.size() == 0) begin
          $display("checker: result delivered at %0t with no request outstanding", $time);
          err_count++;
        end else begin
          head = exp_q.pop_front();
          chk_count++;
          if (out_data !== head.product) begin
            $display("mismatch at %0t: idx %0d expected %h got %h",
                     $time, head.idx, head.product, out_data);
            err_count++;
          end
          // index 0 is exactly one
          if (head.idx == twid_idx_t'(0) && out_data !== head.sample) begin
            $display("mismatch at %0t: idx 0 result %h differs from sample %h",
                     $time, out_data, head.sample);
            err_count++;
          end
          // index 4 is exactly -j, so (re, im) becomes (im, -re)
          if (head.idx == twid_idx_t'(4) &&
              (out_data.re !== head.sample.im || out_data.im !== -head.sample.re)) begin
            $display("mismatch at %0t: idx 4 result %h is not sample %h times -j",
                     $time, out_data, head.sample);
            err_count++;
          end
        end
      end
      if (end_check && !end_done) begin
        end_done = 1'b1;
        if (exp_q.size() != 0) begin
          $display("checker: %0d requests never produced a result", exp_q.size());
          err_count++;
        end
      end
      q_size = exp_q.size();
    end
  end

endmodule

// ==== dv/rotator_tb.sv ====
`timescale 1ns/10ps
`include "cmul_defs.svh"

module rotator_tb #(
  parameter int NUM_MULTS = 1
);
  import fixed_pkg::*;
  import stream_pkg::*;

  localparam int n_random     = 200;
  localparam int n_exact      = 32;
  localparam int n_bp         = 200;
  // one extra slot in the done state of the serial multiplier
  localparam int capacity     = `IN_FIFO_DEPTH + `OUT_FIFO_DEPTH + ((NUM_MULTS == 1) ? 2 : 1);
  localparam int quiet_window = 20;
  localparam int drain_limit  = 400;
  // gaps, back-pressure and the serial multiplier together stay well below this
  localparam int cycles_per_req  = 40;
  localparam int watchdog_cycles =
    (n_random + n_exact + n_bp + capacity) * cycles_per_req + 6 * drain_limit;

  logic     clk;
  logic     reset;
  logic     in_val;
  logic     in_rdy;
  rot_req_t in_req;
  logic     out_val;
  logic     out_rdy;
  cplx_t    out_data;
  logic     end_check;
  int       chk_errors;
  int       pending;
  int       checked;

  logic [15:0] lfsr = 16'd19727;
  logic        toggle_ready;
  rot_req_t    req;
  int          gap;
  int          tb_errors;
  int          err_base;
  int          failed_tests;
  int          tests_run;
  int          accepted;
  int          quiet;

  tb_clock_gen #(.period_ns(40), .reset_cycles(10)) clock_gen_i (.clk(clk), .reset(reset));

  twiddle_rotator_top #(.NUM_MULTS(NUM_MULTS)) dut_i (
    .clk      (clk),
    .reset    (reset),
    .in_val   (in_val),
    .in_rdy   (in_rdy),
    .in_req   (in_req),
    .out_val  (out_val),
    .out_rdy  (out_rdy),
    .out_data (out_data)
  );

  rotator_checker checker_i (
    .clk       (clk),
    .reset     (reset),
    .in_val    (in_val),
    .in_rdy    (in_rdy),
    .in_req    (in_req),
    .out_val   (out_val),
    .out_rdy   (out_rdy),
    .out_data  (out_data),
    .end_check (end_check),
    .errors    (chk_errors),
    .pending   (pending),
    .checked   (checked)
  );

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic rot_req_t random_req();
    rot_req_t    r;
    logic [31:0] bits;
    r.sample.re = take_bits(32);
    r.sample.im = take_bits(32);
    bits        = take_bits(`TWID_ADDR_BITS);
    r.idx       = bits[`TWID_ADDR_BITS-1:0];
    return r;
  endfunction

  // half the time back to back, otherwise up to three idle cycles
  function automatic int random_gap();
    logic [31:0] bits;
    bits = take_bits(3);
    return bits[2] ? 0 : int'(bits[1:0]);
  endfunction

  task automatic step_cycle();
    logic [31:0] bits;
    @(posedge clk);
    if (toggle_ready) begin
      bits = take_bits(1);
      out_rdy <= bits[0];
    end
  endtask

  // hold the request until the input queue takes it
  task automatic send_one(input rot_req_t r, input int idle);
    in_val <= 1'b1;
    in_req <= r;
    step_cycle();
    while (!in_rdy) step_cycle();
    if (idle > 0) begin
      in_val <= 1'b0;
      repeat (idle) step_cycle();
    end
  endtask

  // drain all results, then one report line for the test
  task automatic finish_test(input string name, input int sent);
    int cycles;
    int errs;
    in_val       <= 1'b0;
    out_rdy      <= 1'b1;
    toggle_ready = 1'b0;
    cycles       = 0;
    @(negedge clk);
    while (pending != 0 && cycles < drain_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (pending != 0) begin
      $display("test %s: %0d results still missing after %0d cycles", name, pending, cycles);
      tb_errors++;
    end
    errs = chk_errors + tb_errors - err_base;
    err_base = chk_errors + tb_errors;
    tests_run++;
    if (errs != 0) failed_tests++;
    $display("test %s done: %0d requests, %0d errors", name, sent, errs);
    @(posedge clk);
  endtask

  initial begin
    in_val       <= 1'b0;
    in_req       <= '0;
    out_rdy      <= 1'b1;
    end_check    <= 1'b0;
    toggle_ready = 1'b0;
    tb_errors    = 0;
    err_base     = 0;
    failed_tests = 0;
    tests_run    = 0;

    wait (reset == 1'b0);
    @(negedge clk);
    if (in_rdy !== 1'b1 || out_val !== 1'b0) begin
      $display("mismatch at %0t: after reset in_rdy %b out_val %b", $time, in_rdy, out_val);
      tb_errors++;
    end
    @(posedge clk);
    finish_test("reset_state", 0);

    for (int i = 0; i < n_random; i++) begin
      req = random_req();
      gap = random_gap();
      send_one(req, gap);
    end
    finish_test("random_rotations", n_random);

    // alternate the exact twiddles 1 and -j
    for (int i = 0; i < n_exact; i++) begin
      req     = random_req();
      req.idx = i[0] ? twid_idx_t'(4) : twid_idx_t'(0);
      send_one(req, 0);
    end
    finish_test("exact_twiddles", n_exact);

    toggle_ready = 1'b1;
    for (int i = 0; i < n_bp; i++) begin
      req = random_req();
      gap = random_gap();
      send_one(req, gap);
    end
    finish_test("random_backpressure", n_bp);

    // in_rdy dips while the serial multiplier works, so count until it stays low
    accepted = 0;
    quiet    = 0;
    out_rdy <= 1'b0;
    in_val  <= 1'b1;
    in_req  <= random_req();
    while (quiet < quiet_window) begin
      step_cycle();
      if (in_rdy) begin
        accepted++;
        quiet = 0;
        in_req <= random_req();
      end else begin
        quiet++;
      end
    end
    in_val <= 1'b0;
    if (accepted != capacity) begin
      $display("mismatch at %0t: accepted %0d requests under back-pressure, expected %0d",
               $time, accepted, capacity);
      tb_errors++;
    end
    finish_test("capacity", accepted);

    end_check <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    $display("summary: %0d tests, %0d failed, %0d results checked, %0d errors",
             tests_run, failed_tests, checked, chk_errors + tb_errors);
    if (chk_errors + tb_errors == 0 && failed_tests == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", watchdog_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+rtl
rtl/fixed_pkg.sv
rtl/stream_pkg.sv
rtl/stream_fifo.sv
rtl/twiddle_stage.sv
rtl/complex_multiplier.sv
rtl/twiddle_rotator_top.sv
dv/tb_clock_gen.sv
dv/rotator_checker.sv
dv/rotator_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench once per multiplier count
set -e
cd "$(dirname "$0")"
status=0
for mults in 1 3; do
  verilator --binary --timing -Wno-fatal -f sim.f --top-module rotator_tb \
    -GNUM_MULTS=$mults -Mdir obj_m$mults -o rotator_sim
  ./obj_m$mults/rotator_sim > sim_m$mults.log 2>&1
  cat sim_m$mults.log
  if grep -q "TEST RESULT: PASS" sim_m$mults.log; then
    echo "NUM_MULTS=$mults passed"
  else
    echo "NUM_MULTS=$mults failed"
    status=1
  fi
done
exit $status
